/* common/rec_config.svh */
`ifndef REC_CONFIG_SVH
`define REC_CONFIG_SVH

// cycles a key level must hold before it counts
`define REC_DEB_CYCLES 8

// codec sample width, also the SRAM data width
`define REC_SAMPLE_W 16

// external SRAM word address width
`define REC_ADDR_W 20

// frames per displayed second
`define REC_SAMPLES_PER_SEC 32000

`endif

/* common/rec_pkg.sv */
package rec_pkg;

	// recorder controller states, shown on hex3/hex2
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		REC        = 3'd1,
		REC_PAUSE  = 3'd2,
		PLAY       = 3'd3,
		PLAY_PAUSE = 3'd4
	} rec_state_e;

	// playback modes from the mode switches
	typedef enum logic [1:0] {
		NORMAL = 2'd0,
		FAST   = 2'd1,
		SLOW   = 2'd2
	} play_mode_e;

	// switch value 3 falls back to normal play
	function automatic play_mode_e decode_mode(input logic [1:0] sw);
		case (sw)
			2'd1:    return FAST;
			2'd2:    return SLOW;
			default: return NORMAL;
		endcase
	endfunction

endpackage

/* common/aud_pkg.sv */
`include "rec_config.svh"

package aud_pkg;

	// one signed audio sample
	typedef logic signed [`REC_SAMPLE_W-1:0] sample_t;

	// serial bit phase of one codec direction
	typedef enum logic [1:0] {
		WAIT_FRAME = 2'd0,
		SKIP       = 2'd1,
		SHIFT      = 2'd2,
		DONE       = 2'd3
	} port_phase_e;

endpackage

/* common/sram_if.sv */
`timescale 1ns/10ps
`include "rec_config.svh"

interface sram_if
	import aud_pkg::*;
();
	logic [`REC_ADDR_W-1:0] addr;
	sample_t                wdata;
	sample_t                rdata;
	// one-cycle strobes, never high together
	logic                   we;
	logic                   oe;

	modport ctrl (
		output addr,
		output wdata,
		output we,
		output oe,
		input  rdata
	);

	modport port (
		input  addr,
		input  wdata,
		input  we,
		input  oe,
		output rdata
	);
endinterface

/* source/debounce.sv */
`timescale 1ns/10ps
`include "rec_config.svh"

module debounce (
	input  logic i_clk,
	input  logic i_arst_n,
	input  logic i_in,
	output logic o_neg
);
	localparam int DEB_CYCLES = `REC_DEB_CYCLES;
	localparam int CW = $clog2(DEB_CYCLES + 1);

	// confirmed key level, released key reads high
	logic          level;
	logic [CW-1:0] cnt;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			level <= 1'b1;
			cnt   <= '0;
			o_neg <= 1'b0;
		end else begin
			o_neg <= 1'b0;
			if (i_in == level) begin
				// any bounce back restarts the count
				cnt <= '0;
			end else if (cnt == CW'(DEB_CYCLES - 1)) begin
				level <= i_in;
				cnt   <= '0;
				// pulse only on a confirmed press
				o_neg <= ~i_in;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end
endmodule

/* source/seven_hex_decoder.sv */
`timescale 1ns/10ps

module seven_hex_decoder (
	input  logic [4:0] i_hex,
	output logic [6:0] o_seven_ten,
	output logic [6:0] o_seven_one
);
	logic [3:0] tens;
	logic [3:0] ones;

	// segments active low, g in bit 6 and a in bit 0
	function automatic logic [6:0] seg(input logic [3:0] digit);
		case (digit)
			4'd0:    return 7'b1000000;
			4'd1:    return 7'b1111001;
			4'd2:    return 7'b0100100;
			4'd3:    return 7'b0110000;
			4'd4:    return 7'b0011001;
			4'd5:    return 7'b0010010;
			4'd6:    return 7'b0000010;
			4'd7:    return 7'b1111000;
			4'd8:    return 7'b0000000;
			4'd9:    return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	// 0 to 31 gives tens 0 to 3
	assign tens = 4'(i_hex / 5'd10);
	assign ones = 4'(i_hex % 5'd10);

	assign o_seven_ten = seg(tens);
	assign o_seven_one = seg(ones);
endmodule

/* audio/aud_codec_port.sv */
`timescale 1ns/10ps
`include "rec_config.svh"

module aud_codec_port
	import aud_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_arst_n,
	input  logic    i_bclk,
	input  logic    i_adclrck,
	input  logic    i_daclrck,
	input  logic    i_adcdat,
	input  sample_t i_dac_sample,
	input  logic    i_dac_load,
	output logic    o_dacdat,
	output sample_t o_adc_sample,
	output logic    o_adc_valid,
	output logic    o_dac_req
);
	localparam int SW = `REC_SAMPLE_W;
	// adc_valid lands ten cycles after the last bit's bclk rise
	localparam int VALID_WAIT = 7;

	// two sync flops, the third is history for edge detect
	logic [2:0]    bclk_q;
	logic [2:0]    adclrck_q;
	logic [2:0]    daclrck_q;
	logic [1:0]    adcdat_q;
	logic          bclk_rise;
	logic          bclk_fall;
	logic          adc_frame;
	logic          dac_frame;

	port_phase_e   adc_phase;
	port_phase_e   dac_phase;
	logic [4:0]    adc_cnt;
	logic [4:0]    dac_cnt;
	logic [SW-1:0] adc_shift;
	logic [SW-1:0] dac_shift;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			bclk_q    <= '0;
			adclrck_q <= '0;
			daclrck_q <= '0;
			adcdat_q  <= '0;
		end else begin
			bclk_q    <= {bclk_q[1:0], i_bclk};
			adclrck_q <= {adclrck_q[1:0], i_adclrck};
			daclrck_q <= {daclrck_q[1:0], i_daclrck};
			adcdat_q  <= {adcdat_q[0], i_adcdat};
		end
	end

	assign bclk_rise = bclk_q[1] & ~bclk_q[2];
	assign bclk_fall = ~bclk_q[1] & bclk_q[2];
	// left channel starts when the frame clock falls
	assign adc_frame = ~adclrck_q[1] & adclrck_q[2];
	assign dac_frame = ~daclrck_q[1] & daclrck_q[2];

	// capture side, one idle bclk and then 16 bits MSB first
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			adc_phase   <= WAIT_FRAME;
			adc_cnt     <= '0;
			o_adc_valid <= 1'b0;
		end else begin
			o_adc_valid <= 1'b0;
			case (adc_phase)
				WAIT_FRAME: begin
					if (adc_frame) adc_phase <= SKIP;
				end
				SKIP: begin
					if (bclk_rise) begin
						adc_phase <= SHIFT;
						adc_cnt   <= '0;
					end
				end
				SHIFT: begin
					if (bclk_rise) begin
						adc_cnt <= adc_cnt + 1'b1;
						if (adc_cnt == 5'(SW - 1)) begin
							adc_phase <= DONE;
							adc_cnt   <= '0;
						end
					end
				end
				DONE: begin
					adc_cnt <= adc_cnt + 1'b1;
					if (adc_cnt == 5'(VALID_WAIT)) begin
						o_adc_valid <= 1'b1;
						adc_phase   <= WAIT_FRAME;
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (adc_phase == SHIFT && bclk_rise) adc_shift <= {adc_shift[SW-2:0], adcdat_q[1]};
		if (adc_phase == DONE && adc_cnt == 5'(VALID_WAIT)) o_adc_sample <= adc_shift;
	end

	// playback side, bits change on bclk falling edges
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			dac_phase <= WAIT_FRAME;
			dac_cnt   <= '0;
			dac_shift <= '0;
			o_dac_req <= 1'b0;
			o_dacdat  <= 1'b0;
		end else begin
			o_dac_req <= 1'b0;
			case (dac_phase)
				WAIT_FRAME: begin
					if (dac_frame) begin
						o_dac_req <= 1'b1;
						// silence unless the controller loads a sample
						dac_shift <= '0;
						dac_phase <= SKIP;
					end
				end
				SKIP: begin
					if (bclk_fall) begin
						o_dacdat  <= dac_shift[SW-1];
						dac_shift <= {dac_shift[SW-2:0], 1'b0};
						dac_cnt   <= 5'd1;
						dac_phase <= SHIFT;
					end else if (i_dac_load) begin
						dac_shift <= i_dac_sample;
					end
				end
				SHIFT: begin
					if (bclk_fall) begin
						// the 17th fall shifts out the zero fill
						o_dacdat  <= dac_shift[SW-1];
						dac_shift <= {dac_shift[SW-2:0], 1'b0};
						dac_cnt   <= dac_cnt + 1'b1;
						if (dac_cnt == 5'(SW)) dac_phase <= DONE;
					end
				end
				DONE: begin
					dac_phase <= WAIT_FRAME;
				end
			endcase
		end
	end
endmodule

/* control/rec_ctrl.sv */
`timescale 1ns/10ps
`include "rec_config.svh"

module rec_ctrl
	import rec_pkg::*;
	import aud_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_arst_n,
	input  logic       i_start,
	input  logic       i_pause,
	input  logic       i_stop,
	input  logic       i_rec_play,
	input  logic [1:0] i_mode,
	input  logic [2:0] i_speed,
	input  sample_t    i_adc_sample,
	input  logic       i_adc_valid,
	input  logic       i_dac_req,
	output sample_t    o_dac_sample,
	output logic       o_dac_load,
	output rec_state_e o_state,
	output logic [4:0] o_seconds,
	sram_if.ctrl       sram
);
	localparam int AW = `REC_ADDR_W;
	localparam int SPS = `REC_SAMPLES_PER_SEC;
	localparam int SCW = $clog2(SPS);
	localparam logic [SCW-1:0] SEC_LAST = SCW'(SPS - 1);

	rec_state_e     state;
	play_mode_e     mode;
	logic [AW-1:0]  addr;
	logic [AW-1:0]  end_addr;
	logic [AW-1:0]  next_addr;
	logic [2:0]     hold_cnt;
	logic           hold_done;
	logic           wr_pend;
	logic           load_pend;
	logic [SCW-1:0] sec_cnt;
	sample_t        wr_data;

	assign mode      = decode_mode(i_mode);
	assign hold_done = (hold_cnt >= i_speed);

	// playback address after the current read
	always_comb begin
		case (mode)
			FAST:    next_addr = addr + AW'(i_speed) + 1'b1;
			SLOW:    next_addr = hold_done ? addr + 1'b1 : addr;
			default: next_addr = addr + 1'b1;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state    <= IDLE;
			addr     <= '0;
			end_addr <= '0;
			hold_cnt <= '0;
		end else begin
			if (sram.we) addr <= addr + 1'b1;
			if (sram.oe) begin
				addr     <= next_addr;
				hold_cnt <= (mode != SLOW || hold_done) ? '0 : hold_cnt + 1'b1;
			end
			case (state)
				IDLE: begin
					// play needs something recorded
					if (i_start && (i_rec_play || end_addr != '0)) begin
						addr     <= '0;
						hold_cnt <= '0;
						state    <= i_rec_play ? REC : PLAY;
					end
				end
				REC, REC_PAUSE: begin
					if (i_stop) begin
						end_addr <= addr + AW'(sram.we);
						state    <= IDLE;
					end else if (i_pause) begin
						state <= (state == REC) ? REC_PAUSE : REC;
					end
				end
				PLAY, PLAY_PAUSE: begin
					if (i_stop) state <= IDLE;
					else if (i_pause) state <= (state == PLAY) ? PLAY_PAUSE : PLAY;
				end
				default: state <= IDLE;
			endcase
			// end of the recording wins over a pause press
			if (sram.oe && next_addr >= end_addr) state <= IDLE;
		end
	end

	// write two cycles after adc_valid, read then capture then load
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_pend    <= 1'b0;
			sram.we    <= 1'b0;
			sram.oe    <= 1'b0;
			load_pend  <= 1'b0;
			o_dac_load <= 1'b0;
		end else begin
			wr_pend    <= i_adc_valid && state == REC;
			sram.we    <= wr_pend;
			sram.oe    <= i_dac_req && state == PLAY;
			load_pend  <= sram.oe;
			o_dac_load <= load_pend;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_adc_valid) wr_data <= i_adc_sample;
		if (sram.oe) o_dac_sample <= sram.rdata;
	end

	// elapsed recording time, saturates at 31 s
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sec_cnt   <= '0;
			o_seconds <= '0;
		end else if (state == IDLE && i_start && i_rec_play) begin
			sec_cnt   <= '0;
			o_seconds <= '0;
		end else if (sram.we) begin
			if (sec_cnt == SEC_LAST) begin
				sec_cnt <= '0;
				if (o_seconds != 5'd31) o_seconds <= o_seconds + 1'b1;
			end else begin
				sec_cnt <= sec_cnt + 1'b1;
			end
		end
	end

	assign sram.addr  = addr;
	assign sram.wdata = wr_data;
	assign o_state    = state;
endmodule

/* source/rec_top.sv */
`timescale 1ns/10ps
`include "rec_config.svh"

module rec_top
	import rec_pkg::*;
	import aud_pkg::*;
(
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  logic [2:0]              i_key,
	input  logic                    i_rec_play,
	input  logic [1:0]              i_mode,
	input  logic [2:0]              i_speed,
	input  logic                    i_bclk,
	input  logic                    i_adclrck,
	input  logic                    i_daclrck,
	input  logic                    i_adcdat,
	output logic                    o_dacdat,
	output logic [`REC_ADDR_W-1:0]  o_sram_addr,
	inout  wire [`REC_SAMPLE_W-1:0] io_sram_dq,
	output logic                    o_sram_we_n,
	output logic                    o_sram_ce_n,
	output logic                    o_sram_oe_n,
	output logic                    o_sram_lb_n,
	output logic                    o_sram_ub_n,
	output logic [6:0]              o_hex0,
	output logic [6:0]              o_hex1,
	output logic [6:0]              o_hex2,
	output logic [6:0]              o_hex3,
	output logic [6:0]              o_hex4,
	output logic [6:0]              o_hex5,
	output logic [6:0]              o_hex6,
	output logic [6:0]              o_hex7
);
	logic       key_start;
	logic       key_pause;
	logic       key_stop;
	sample_t    adc_sample;
	logic       adc_valid;
	logic       dac_req;
	sample_t    dac_sample;
	logic       dac_load;
	rec_state_e state;
	logic [4:0] seconds;

	sram_if sram ();

	// key 0 start, key 1 pause, key 2 stop
	debounce u_deb_start (.i_clk, .i_arst_n, .i_in(i_key[0]), .o_neg(key_start));
	debounce u_deb_pause (.i_clk, .i_arst_n, .i_in(i_key[1]), .o_neg(key_pause));
	debounce u_deb_stop  (.i_clk, .i_arst_n, .i_in(i_key[2]), .o_neg(key_stop));

	aud_codec_port u_port (
		.i_clk, .i_arst_n,
		.i_bclk, .i_adclrck, .i_daclrck, .i_adcdat,
		.i_dac_sample(dac_sample),
		.i_dac_load  (dac_load),
		.o_dacdat,
		.o_adc_sample(adc_sample),
		.o_adc_valid (adc_valid),
		.o_dac_req   (dac_req)
	);

	rec_ctrl u_ctrl (
		.i_clk, .i_arst_n,
		.i_start     (key_start),
		.i_pause     (key_pause),
		.i_stop      (key_stop),
		.i_rec_play, .i_mode, .i_speed,
		.i_adc_sample(adc_sample),
		.i_adc_valid (adc_valid),
		.i_dac_req   (dac_req),
		.o_dac_sample(dac_sample),
		.o_dac_load  (dac_load),
		.o_state     (state),
		.o_seconds   (seconds),
		.sram        (sram.ctrl)
	);

	// data bus driven only during a write
	assign io_sram_dq  = sram.we ? sram.wdata : 'z;
	assign sram.rdata  = io_sram_dq;
	assign o_sram_addr = sram.addr;
	assign o_sram_we_n = ~sram.we;
	assign o_sram_oe_n = ~sram.oe;
	assign o_sram_ce_n = ~(sram.we | sram.oe);
	assign o_sram_lb_n = 1'b0;
	assign o_sram_ub_n = 1'b0;

	seven_hex_decoder u_dec_sec   (.i_hex(seconds),
		.o_seven_ten(o_hex1), .o_seven_one(o_hex0));
	seven_hex_decoder u_dec_state (.i_hex({2'b00, state}),
		.o_seven_ten(o_hex3), .o_seven_one(o_hex2));
	seven_hex_decoder u_dec_speed (.i_hex({2'b00, i_speed}),
		.o_seven_ten(o_hex5), .o_seven_one(o_hex4));
	seven_hex_decoder u_dec_mode  (.i_hex({3'b000, i_mode}),
		.o_seven_ten(o_hex7), .o_seven_one(o_hex6));
endmodule

/* verif/rec_props.sv */
`timescale 1ns/10ps
`include "rec_config.svh"

module rec_props
	import rec_pkg::*;
(
	input logic                   i_clk,
	input logic                   i_arst_n,
	input logic                   i_we,
	input logic                   i_oe,
	input rec_state_e             i_state,
	input logic [`REC_ADDR_W-1:0] i_addr,
	input logic [`REC_ADDR_W-1:0] i_end_addr
);
	// write and read share one data bus
	a_strobe_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(i_we && i_oe))
		else $error("SRAM we and oe are high in the same cycle");

	// single-cycle strobes
	a_we_pulse: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_we |=> !i_we)
		else $error("SRAM we stays high for more than one cycle");

	a_oe_pulse: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_oe |=> !i_oe)
		else $error("SRAM oe stays high for more than one cycle");

	// playback never reads past the recorded samples
	a_rd_range: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_oe |-> i_addr < i_end_addr)
		else $error("SRAM read at or beyond the end of the recording");

	// a playing state always points inside the recording
	a_play_range: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_state inside {PLAY, PLAY_PAUSE}) |-> i_addr < i_end_addr)
		else $error("controller plays with an address beyond the recording");
endmodule

/* verif/rec_tb.sv */
`timescale 1ns/10ps

module rec_tb;
	localparam int N            = 6;
	localparam int NORM_BASE    = 6;
	localparam int FAST_BASE    = 12;
	localparam int SLOW_BASE    = 15;
	localparam int GOLD_WORDS   = 33;
	localparam int RX_DEPTH     = 256;
	localparam int FRAME_CYCLES = 320;
	localparam int CLK_NS       = 40;
	// slow play at speed 2 is the longest test
	localparam int TEST_FRAMES  = 3 * N + 4;
	localparam int WATCHDOG_NS  = (5 * TEST_FRAMES + 20) * FRAME_CYCLES * CLK_NS;

	logic        clk = 1'b0;
	logic        arst_n;
	logic [2:0]  key;
	logic        rec_play;
	logic [1:0]  mode;
	logic [2:0]  speed;
	logic        bclk = 1'b0;
	logic        lrck = 1'b1;
	logic        adcdat = 1'b0;
	wire         dacdat;
	wire  [19:0] sram_addr;
	wire  [15:0] sram_dq;
	wire         we_n;
	wire         ce_n;
	wire         oe_n;
	wire         lb_n;
	wire         ub_n;
	wire  [6:0]  hex0;
	wire  [6:0]  hex1;
	wire  [6:0]  hex2;
	wire  [6:0]  hex3;
	wire  [6:0]  hex4;
	wire  [6:0]  hex5;
	wire  [6:0]  hex6;
	wire  [6:0]  hex7;

	logic [15:0] gold [0:GOLD_WORDS-1];
	logic [15:0] mem [0:1023];
	logic [15:0] rx_words [0:RX_DEPTH-1];
	logic [15:0] adc_word = '0;
	logic [15:0] dac_shift = '0;
	logic        adc_feed = 1'b0;
	int          tick = 0;
	int          adc_ptr = 0;
	int          rx_count = 0;
	int          rd_cnt = 0;
	int          n_value_err = 0;
	int          n_other_err = 0;

	rec_top DUT (
		.i_clk      (clk),
		.i_arst_n   (arst_n),
		.i_key      (key),
		.i_rec_play (rec_play),
		.i_mode     (mode),
		.i_speed    (speed),
		.i_bclk     (bclk),
		.i_adclrck  (lrck),
		.i_daclrck  (lrck),
		.i_adcdat   (adcdat),
		.o_dacdat   (dacdat),
		.o_sram_addr(sram_addr),
		.io_sram_dq (sram_dq),
		.o_sram_we_n(we_n),
		.o_sram_ce_n(ce_n),
		.o_sram_oe_n(oe_n),
		.o_sram_lb_n(lb_n),
		.o_sram_ub_n(ub_n),
		.o_hex0     (hex0),
		.o_hex1     (hex1),
		.o_hex2     (hex2),
		.o_hex3     (hex3),
		.o_hex4     (hex4),
		.o_hex5     (hex5),
		.o_hex6     (hex6),
		.o_hex7     (hex7)
	);

	bind rec_ctrl rec_props u_props (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_we      (sram.we),
		.i_oe      (sram.oe),
		.i_state   (state),
		.i_addr    (addr),
		.i_end_addr(end_addr)
	);

	always #20 clk = ~clk;

	// codec master, bclk of 8 cycles and 20 bclk per lrck half
	always @(posedge clk) begin
		tick <= (tick == FRAME_CYCLES - 1) ? 0 : tick + 1;
		bclk <= (tick % 8) >= 4;
		lrck <= (tick / 8) >= 20;
		if (tick == 0) begin
			if (adc_feed && adc_ptr < N) begin
				adc_word <= gold[adc_ptr];
				adc_ptr  <= adc_ptr + 1;
			end else begin
				adc_word <= '0;
			end
		end
		// left channel bits sit in bclk 1 to 16, MSB first
		if (tick % 8 == 0 && tick >= 8 && tick <= 128) adcdat <= adc_word[16 - tick / 8];
		// DAC bits taken in the high half of each bclk
		if (tick % 8 == 6 && tick >= 14 && tick <= 134) dac_shift <= {dac_shift[14:0], dacdat};
		if (tick == 142) begin
			rx_words[rx_count % RX_DEPTH] <= dac_shift;
			rx_count <= rx_count + 1;
		end
	end

	// async SRAM, write while we_n is low, combinational read
	assign sram_dq = oe_n ? 16'hzzzz : mem[sram_addr[9:0]];

	always @(posedge clk) begin
		if (!we_n) mem[sram_addr[9:0]] <= sram_dq;
		if (!oe_n) rd_cnt <= rd_cnt + 1;
		// a 16-bit access needs chip enable and both byte lanes
		if ((!we_n || !oe_n) && {ce_n, lb_n, ub_n} !== 3'b000) begin
			n_other_err++;
			$display("SRAM access at %0t without chip enable or both byte lanes", $time);
		end
	end

	// standard active-low digits, g in bit 6
	function automatic logic [6:0] seg_pattern(input int digit);
		case (digit)
			0:       return 7'b1000000;
			1:       return 7'b1111001;
			2:       return 7'b0100100;
			3:       return 7'b0110000;
			4:       return 7'b0011001;
			5:       return 7'b0010010;
			6:       return 7'b0000010;
			7:       return 7'b1111000;
			8:       return 7'b0000000;
			9:       return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	task automatic report_mismatch(input string test, input logic [15:0] expected,
		input logic [15:0] actual);
		n_value_err++;
		$display("Fail %s: expected %h, actual %h at %0t", test, expected, actual, $time);
	endtask

	task automatic wait_tick(input int t);
		@(posedge clk);
		while (tick != t) @(posedge clk);
	endtask

	// long enough low and high for the debouncer
	task automatic press_key(input int idx);
		key[idx] <= 1'b0;
		repeat (16) @(posedge clk);
		key[idx] <= 1'b1;
		repeat (16) @(posedge clk);
	endtask

	task automatic play_and_check(input string test, input logic [1:0] sw_mode,
		input logic [2:0] sw_speed, input int gbase, input int len);
		int base;
		int i;
		mode     <= sw_mode;
		speed    <= sw_speed;
		rec_play <= 1'b0;
		// start late in a frame so the next frame reads address 0
		wait_tick(170);
		press_key(0);
		if (hex2 !== seg_pattern(3)) report_mismatch(test, seg_pattern(3), hex2);
		base = rx_count;
		while (rx_count < base + len) @(posedge clk);
		for (i = 0; i < len; i++) begin
			if (rx_words[(base + i) % RX_DEPTH] !== gold[gbase + i])
				report_mismatch(test, gold[gbase + i], rx_words[(base + i) % RX_DEPTH]);
		end
		if (hex2 !== seg_pattern(0)) report_mismatch(test, seg_pattern(0), hex2);
	endtask

	initial begin
		int base;
		int i;
		int rd_snap;
		logic [15:0] expected;
		arst_n   = 1'b0;
		key      = 3'b111;
		rec_play = 1'b1;
		mode     = 2'd3;
		speed    = 3'd5;
		$readmemh("verif/rec_golden.txt", gold);
		if (gold[GOLD_WORDS-1] === 16'hxxxx) begin
			n_other_err++;
			$display("golden file verif/rec_golden.txt is missing or too short");
		end
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);

		if (hex0 !== seg_pattern(0)) report_mismatch("reset_display", seg_pattern(0), hex0);
		if (hex1 !== seg_pattern(0)) report_mismatch("reset_display", seg_pattern(0), hex1);
		if (hex2 !== seg_pattern(0)) report_mismatch("reset_display", seg_pattern(0), hex2);
		if (hex3 !== seg_pattern(0)) report_mismatch("reset_display", seg_pattern(0), hex3);
		if (hex4 !== seg_pattern(5)) report_mismatch("reset_display", seg_pattern(5), hex4);
		if (hex5 !== seg_pattern(0)) report_mismatch("reset_display", seg_pattern(0), hex5);
		if (hex6 !== seg_pattern(3)) report_mismatch("reset_display", seg_pattern(3), hex6);
		if (hex7 !== seg_pattern(0)) report_mismatch("reset_display", seg_pattern(0), hex7);

		// record after the frame's sample has passed, feed from the next frame
		wait_tick(170);
		press_key(0);
		if (hex2 !== seg_pattern(1)) report_mismatch("record_normal", seg_pattern(1), hex2);
		adc_feed <= 1'b1;
		while (adc_ptr < N) @(posedge clk);
		wait_tick(200);
		press_key(2);
		adc_feed <= 1'b0;
		if (hex2 !== seg_pattern(0)) report_mismatch("record_normal", seg_pattern(0), hex2);
		play_and_check("record_normal", 2'd0, 3'd0, NORM_BASE, N);

		play_and_check("fast_play", 2'd1, 3'd1, FAST_BASE, 3);
		play_and_check("slow_play", 2'd2, 3'd2, SLOW_BASE, 3 * N);

		// two samples, two paused frames, then the rest
		mode     <= 2'd0;
		speed    <= 3'd0;
		rec_play <= 1'b0;
		wait_tick(170);
		press_key(0);
		base = rx_count;
		while (rx_count < base + 2) @(posedge clk);
		wait_tick(170);
		press_key(1);
		if (hex2 !== seg_pattern(4)) report_mismatch("pause_play", seg_pattern(4), hex2);
		rd_snap = rd_cnt;
		while (rx_count < base + 4) @(posedge clk);
		if (rd_cnt !== rd_snap) report_mismatch("pause_play", rd_snap, rd_cnt);
		wait_tick(170);
		press_key(1);
		if (hex2 !== seg_pattern(3)) report_mismatch("pause_play", seg_pattern(3), hex2);
		while (rx_count < base + N + 2) @(posedge clk);
		for (i = 0; i < N + 2; i++) begin
			if (i < 2) expected = gold[NORM_BASE + i];
			else if (i < 4) expected = 16'h0000;
			else expected = gold[NORM_BASE + i - 2];
			if (rx_words[(base + i) % RX_DEPTH] !== expected)
				report_mismatch("pause_play", expected, rx_words[(base + i) % RX_DEPTH]);
		end
		if (hex2 !== seg_pattern(0)) report_mismatch("pause_play", seg_pattern(0), hex2);

		$display("value errors: %0d, other errors: %0d", n_value_err, n_other_err);
		if (n_value_err == 0 && n_other_err == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Done: errors found");
		$finish;
	end
endmodule

/* verif/rec_golden.txt */
// one 16-bit hex word per entry, several entries per line
// words 0-5 ADC input, 6-11 normal, 12-14 fast speed 1, 15-32 slow speed 2

// ADC samples in recording order
1234 a5c3 7f01 8000 0f0f c35a

// normal playback, every sample in order
1234 a5c3 7f01 8000 0f0f c35a

// fast playback with speed 1, every second sample
1234 7f01 0f0f

// slow playback with speed 2, each sample three times
1234 1234 1234
a5c3 a5c3 a5c3
7f01 7f01 7f01
8000 8000 8000
0f0f 0f0f 0f0f
c35a c35a c35a

/* list.f */
+incdir+common
common/rec_pkg.sv
common/aud_pkg.sv
common/sram_if.sv
source/debounce.sv
source/seven_hex_decoder.sv
audio/aud_codec_port.sv
control/rec_ctrl.sv
source/rec_top.sv
verif/rec_props.sv
verif/rec_tb.sv

/* Bender.yml */
package:
  name: rec_core

export_include_dirs:
  - common

sources:
  - files:
      - common/rec_pkg.sv
      - common/aud_pkg.sv
      - common/sram_if.sv
      - source/debounce.sv
      - source/seven_hex_decoder.sv
      - audio/aud_codec_port.sv
      - control/rec_ctrl.sv
      - source/rec_top.sv
  - target: test
    files:
      - verif/rec_props.sv
      - verif/rec_tb.sv
